// ==== cw_io_regs_cfg.svh ====
`ifndef CW_IO_REGS_CFG_SVH
`define CW_IO_REGS_CFG_SVH

// register map, byte-wide bus
`define CW_EXTCLK_ADDR 38
`define CW_TRIGSRC_ADDR 39
`define CW_TRIGMOD_ADDR 40
`define CW_IOROUTE_ADDR 55
`define CW_IOREAD_ADDR 59 // read-only pin snapshot

`define CW_EXTCLK_RESET 8'h03 // rear input clock, aux line carries trigger
`define CW_TRIGSRC_RESET 8'h01 // front panel A only, OR mode
`define CW_TRIGMOD_RESET 8'h00 // edge trigger module
`define CW_IOROUTE_RESET 64'h0000_0000_0000_0201 // pin 1 TX, pin 2 RX

`define CW_IOROUTE_BYTES 8
`define CW_NUM_PINS 4
`define CW_NUM_TRIG_SRC 6

`define CW_IOR_GLITCH_BYTE 4 // bits 1:0 glitch outputs A/B
`define CW_IOR_AVRPROG_BIT 40
`define CW_IOR_POWEROFF_BIT 41
`define CW_IOR_EXTGPIO_BYTE 6 // nrst, pdid, pdic enable/level pairs

// bit positions inside one pin routing byte
`define CW_PIN_TX 0
`define CW_PIN_RX 1
`define CW_PIN_USIO 2
`define CW_PIN_USII 3
`define CW_PIN_USOC 4 // open-collector USI, pin 3 only
`define CW_PIN_TXOC 5 // open-collector TX, pin 3 only
`define CW_PIN_LEVEL 6
`define CW_PIN_GPIO 7

`endif

// ==== cw_io_regs_pkg.sv ====
`default_nettype none

package cw_io_regs_pkg;

	typedef logic [5:0] reg_addr_t; // register bus address
	typedef logic [15:0] byte_cnt_t; // byte index within a multi-byte register
	typedef logic [7:0] cfg_byte_t; // one register byte
	typedef logic [15:0] hyp_len_t; // register length reported to host

	// whole routing block, byte n lives at bits 8n+7:8n
	typedef logic [63:0] io_route_t;

	typedef logic [3:0] pin_vec_t; // one bit per target pin

	// trigsrc bits 7:6
	typedef logic [1:0] trig_comb_t;

	// trigmod bits 2:0
	typedef logic [2:0] trig_module_t;

endpackage

`default_nettype wire

// ==== cw_reg_bank.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "cw_io_regs_cfg.svh"

module cw_reg_bank (
	input wire logic clk,
	input wire logic reset,
	input wire cw_io_regs_pkg::reg_addr_t reg_address_i, // write address
	input wire cw_io_regs_pkg::byte_cnt_t reg_bytecnt_i, // byte select for routing block
	input wire cw_io_regs_pkg::cfg_byte_t reg_datai_i, // write data
	input wire logic reg_write_i, // one-cycle write strobe
	output cw_io_regs_pkg::cfg_byte_t extclk_cfg_o,
	output cw_io_regs_pkg::cfg_byte_t trigsrc_cfg_o,
	output cw_io_regs_pkg::cfg_byte_t trigmod_cfg_o,
	output cw_io_regs_pkg::io_route_t ioroute_cfg_o
);

	logic [5:0] byte_base; // bit offset of selected routing byte

	assign byte_base = {reg_bytecnt_i[2:0], 3'b000}; // only 8 bytes, low 3 bits pick

	always_ff @(posedge clk) begin
		if (reset) begin
			extclk_cfg_o <= `CW_EXTCLK_RESET;
			trigsrc_cfg_o <= `CW_TRIGSRC_RESET;
			trigmod_cfg_o <= `CW_TRIGMOD_RESET;
			ioroute_cfg_o <= `CW_IOROUTE_RESET;
		end else if (reg_write_i) begin
			case (reg_address_i)
				`CW_EXTCLK_ADDR: begin
					extclk_cfg_o <= reg_datai_i;
				end
				`CW_TRIGSRC_ADDR: begin
					trigsrc_cfg_o <= reg_datai_i;
				end
				`CW_TRIGMOD_ADDR: begin
					trigmod_cfg_o <= reg_datai_i;
				end
				`CW_IOROUTE_ADDR: begin
					ioroute_cfg_o[byte_base +: 8] <= reg_datai_i; // byte-indexed write
				end
				default: begin
					// IOREAD and unmapped addresses are ignored
				end
			endcase
		end
	end

	// the snapshot register is read-only, a write there must leave the bank alone
	a_ioread_no_write: assert property (@(posedge clk) disable iff (reset)
		(reg_write_i && (reg_address_i == `CW_IOREAD_ADDR)) |=>
		$stable({extclk_cfg_o, trigsrc_cfg_o, trigmod_cfg_o, ioroute_cfg_o}))
		else $error("register changed after write to IOREAD address");

endmodule

`default_nettype wire

// ==== cw_reg_readback.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "cw_io_regs_cfg.svh"

module cw_reg_readback (
	input wire logic clk,
	input wire logic reset,
	input wire cw_io_regs_pkg::reg_addr_t reg_address_i,
	input wire cw_io_regs_pkg::byte_cnt_t reg_bytecnt_i,
	input wire logic reg_read_i, // read strobe
	input wire logic reg_addrvalid_i, // address phase valid
	input wire cw_io_regs_pkg::reg_addr_t reg_hypaddress_i, // length query address
	input wire cw_io_regs_pkg::cfg_byte_t extclk_cfg_i,
	input wire cw_io_regs_pkg::cfg_byte_t trigsrc_cfg_i,
	input wire cw_io_regs_pkg::cfg_byte_t trigmod_cfg_i,
	input wire cw_io_regs_pkg::io_route_t ioroute_cfg_i,
	input wire cw_io_regs_pkg::pin_vec_t pins_in_i, // pad inputs
	output cw_io_regs_pkg::cfg_byte_t reg_datao_o,
	output logic reg_rdvalid_o,
	output cw_io_regs_pkg::hyp_len_t reg_hyplen_o
);

	cw_io_regs_pkg::pin_vec_t pins_snap; // IOREAD contents
	logic [5:0] byte_base;
	logic addr_known; // address is one of the five registers

	assign byte_base = {reg_bytecnt_i[2:0], 3'b000};

	always_comb begin
		case (reg_address_i)
			`CW_EXTCLK_ADDR, `CW_TRIGSRC_ADDR, `CW_TRIGMOD_ADDR,
			`CW_IOROUTE_ADDR, `CW_IOREAD_ADDR: addr_known = 1'b1;
			default: addr_known = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pins_snap <= '0;
			reg_rdvalid_o <= 1'b0;
		end else begin
			pins_snap <= pins_in_i; // one cycle of sampling before the read
			reg_rdvalid_o <= reg_addrvalid_i & addr_known; // drops as soon as addrvalid goes
		end
	end

	// read byte captured on the strobe, cleared once the address phase ends
	always_ff @(posedge clk) begin
		if (reset) begin
			reg_datao_o <= '0;
		end else if (!(reg_addrvalid_i & addr_known)) begin
			reg_datao_o <= '0; // bus idles at zero
		end else if (reg_read_i) begin
			case (reg_address_i)
				`CW_EXTCLK_ADDR: reg_datao_o <= extclk_cfg_i;
				`CW_TRIGSRC_ADDR: reg_datao_o <= trigsrc_cfg_i;
				`CW_TRIGMOD_ADDR: reg_datao_o <= trigmod_cfg_i;
				`CW_IOROUTE_ADDR: reg_datao_o <= ioroute_cfg_i[byte_base +: 8];
				`CW_IOREAD_ADDR: reg_datao_o <= {4'b0000, pins_snap};
				default: reg_datao_o <= '0;
			endcase
		end
	end

	// length lookup for the host, purely combinational
	always_comb begin
		case (reg_hypaddress_i)
			`CW_EXTCLK_ADDR, `CW_TRIGSRC_ADDR, `CW_TRIGMOD_ADDR,
			`CW_IOREAD_ADDR: reg_hyplen_o = 16'd1;
			`CW_IOROUTE_ADDR: reg_hyplen_o = 16'(`CW_IOROUTE_BYTES);
			default: reg_hyplen_o = 16'd0;
		endcase
	end

	a_datao_idle_zero: assert property (@(posedge clk) disable iff (reset)
		!reg_rdvalid_o |-> (reg_datao_o == '0))
		else $error("read data nonzero while read-valid is low");

endmodule

`default_nettype wire

// ==== cw_trigger_clock_route.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "cw_io_regs_cfg.svh"

module cw_trigger_clock_route (
	input wire cw_io_regs_pkg::cfg_byte_t trigsrc_cfg_i, // [7:6] mode, [5:0] enables
	input wire cw_io_regs_pkg::cfg_byte_t trigmod_cfg_i, // [3] aux out, [2:0] module
	input wire cw_io_regs_pkg::cfg_byte_t extclk_cfg_i, // [4:3] aux src, [2:0] clk sel
	input wire logic trigger_fpa_i,
	input wire logic trigger_nrst_i,
	input wire cw_io_regs_pkg::pin_vec_t trigger_io_i,
	input wire logic trigger_advio_i,
	input wire logic trigger_anapattern_i,
	input wire logic trigger_decodedio_i,
	input wire logic extclk_fpb_i,
	input wire logic extclk_pll_i,
	input wire logic extclk_rearin_i,
	input wire logic clkgen_i,
	input wire logic glitchclk_i,
	output logic trigger_ext_o, // combined external trigger
	output logic trigger_o, // trigger to capture system
	output logic extclk_o,
	output logic fpa_o, // front panel aux line value
	output logic fpa_oe_o // aux line drive enable
);

	logic [`CW_NUM_TRIG_SRC-1:0] src_lines; // fpa, nrst, io1..io4 from bit 0 up
	logic [`CW_NUM_TRIG_SRC-1:0] src_en;
	logic trig_or;
	logic trig_and;
	cw_io_regs_pkg::trig_comb_t comb_mode;
	cw_io_regs_pkg::trig_module_t mod_sel;

	assign src_lines = {trigger_io_i, trigger_nrst_i, trigger_fpa_i};
	assign src_en = trigsrc_cfg_i[`CW_NUM_TRIG_SRC-1:0];
	assign comb_mode = trigsrc_cfg_i[7:6];
	assign mod_sel = trigmod_cfg_i[2:0];

	assign trig_or = |(src_en & src_lines); // nothing enabled gives 0
	assign trig_and = &(~src_en | src_lines); // disabled lines count as 1

	always_comb begin
		case (comb_mode)
			2'd0: trigger_ext_o = trig_or;
			2'd1: trigger_ext_o = trig_and;
			2'd2: trigger_ext_o = ~trig_and; // NAND
			default: trigger_ext_o = 1'b0;
		endcase
		case (mod_sel)
			3'd0: trigger_o = trigger_ext_o; // edge module takes the combined line
			3'd1: trigger_o = trigger_advio_i;
			3'd2: trigger_o = trigger_anapattern_i;
			3'd3: trigger_o = trigger_decodedio_i;
			default: trigger_o = 1'b0;
		endcase
	end

	// fabric mux, no phase relation assumed between sources
	always_comb begin
		case (extclk_cfg_i[2:0])
			3'd1: extclk_o = extclk_fpb_i;
			3'd2: extclk_o = extclk_pll_i;
			3'd3: extclk_o = extclk_rearin_i;
			default: extclk_o = 1'b0;
		endcase
	end

	always_comb begin
		fpa_oe_o = 1'b1;
		if (trigmod_cfg_i[3]) begin
			fpa_o = trigger_o; // trigger output request wins
		end else begin
			case (extclk_cfg_i[4:3])
				2'd0: fpa_o = trigger_o;
				2'd1: fpa_o = clkgen_i;
				2'd2: fpa_o = glitchclk_i;
				default: begin
					fpa_o = 1'b0;
					fpa_oe_o = 1'b0; // released, usable as input
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== cw_target_io_route.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "cw_io_regs_cfg.svh"

module cw_target_io_route (
	input wire logic clk,
	input wire logic reset,
	input wire cw_io_regs_pkg::io_route_t ioroute_cfg_i,
	input wire cw_io_regs_pkg::pin_vec_t targetio_i, // pad inputs
	input wire logic uart_tx_i,
	input wire logic usi_out_i,
	output cw_io_regs_pkg::pin_vec_t targetio_o,
	output cw_io_regs_pkg::pin_vec_t targetio_oe_o,
	output cw_io_regs_pkg::pin_vec_t pins_in_o, // pads as read, to snapshot
	output logic uart_rx_o,
	output logic usi_in_o,
	output logic targetpower_off_o,
	output logic enable_avrprog_o,
	output logic [1:0] hsglitch_en_o, // glitch outputs A, B
	output logic enable_output_nrst_o,
	output logic output_nrst_o,
	output logic enable_output_pdid_o,
	output logic output_pdid_o,
	output logic enable_output_pdic_o,
	output logic output_pdic_o
);

	logic power_off_q; // pins go high-z while set

	always_ff @(posedge clk) begin
		if (reset) begin
			power_off_q <= 1'b0;
		end else begin
			power_off_q <= ioroute_cfg_i[`CW_IOR_POWEROFF_BIT];
		end
	end

	assign targetpower_off_o = power_off_q;

	// per-pin output select, lowest listed source wins
	always_comb begin
		cw_io_regs_pkg::cfg_byte_t pin_cfg;
		targetio_o = '0;
		targetio_oe_o = '0;
		for (int p = 0; p < `CW_NUM_PINS; p++) begin
			pin_cfg = ioroute_cfg_i[p*8 +: 8];
			if (power_off_q) begin
				targetio_oe_o[p] = 1'b0;
			end else if (pin_cfg[`CW_PIN_TX]) begin
				targetio_o[p] = uart_tx_i;
				targetio_oe_o[p] = 1'b1;
			end else if (pin_cfg[`CW_PIN_USIO]) begin
				targetio_o[p] = usi_out_i;
				targetio_oe_o[p] = 1'b1;
			end else if ((p == 2) && pin_cfg[`CW_PIN_USOC]) begin
				targetio_oe_o[p] = ~usi_out_i; // pull low only, pin 3
			end else if ((p == 2) && pin_cfg[`CW_PIN_TXOC]) begin
				targetio_oe_o[p] = ~uart_tx_i;
			end else if (pin_cfg[`CW_PIN_GPIO]) begin
				targetio_o[p] = pin_cfg[`CW_PIN_LEVEL]; // fixed level
				targetio_oe_o[p] = 1'b1;
			end
		end
	end

	// receive select, walk down so the lowest claiming pin is applied last
	always_comb begin
		uart_rx_o = 1'b1; // idle high when unrouted
		usi_in_o = 1'b1;
		for (int p = `CW_NUM_PINS - 1; p >= 0; p--) begin
			if (ioroute_cfg_i[p*8 + `CW_PIN_RX]) uart_rx_o = targetio_i[p];
			if (ioroute_cfg_i[p*8 + `CW_PIN_USII]) usi_in_o = targetio_i[p];
		end
	end

	assign pins_in_o = targetio_i;

	assign enable_avrprog_o = ioroute_cfg_i[`CW_IOR_AVRPROG_BIT];
	assign hsglitch_en_o = ioroute_cfg_i[`CW_IOR_GLITCH_BYTE*8 +: 2];

	assign enable_output_nrst_o = ioroute_cfg_i[`CW_IOR_EXTGPIO_BYTE*8 + 0];
	assign output_nrst_o = ioroute_cfg_i[`CW_IOR_EXTGPIO_BYTE*8 + 1];
	assign enable_output_pdid_o = ioroute_cfg_i[`CW_IOR_EXTGPIO_BYTE*8 + 2];
	assign output_pdid_o = ioroute_cfg_i[`CW_IOR_EXTGPIO_BYTE*8 + 3];
	assign enable_output_pdic_o = ioroute_cfg_i[`CW_IOR_EXTGPIO_BYTE*8 + 4];
	assign output_pdic_o = ioroute_cfg_i[`CW_IOR_EXTGPIO_BYTE*8 + 5];

	// a set power-off bit must have all pins released by the next cycle
	a_poweroff_releases: assert property (@(posedge clk) disable iff (reset)
		ioroute_cfg_i[`CW_IOR_POWEROFF_BIT] |=> (targetio_oe_o == '0))
		else $error("target pin driven while power is off");

endmodule

`default_nettype wire

// ==== cw_io_regs_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module cw_io_regs_top (
	input wire logic clk,
	input wire logic reset,
	input wire cw_io_regs_pkg::reg_addr_t reg_address_i,
	input wire cw_io_regs_pkg::byte_cnt_t reg_bytecnt_i,
	input wire cw_io_regs_pkg::cfg_byte_t reg_datai_i,
	input wire logic reg_read_i,
	input wire logic reg_write_i,
	input wire logic reg_addrvalid_i,
	input wire cw_io_regs_pkg::reg_addr_t reg_hypaddress_i,
	output cw_io_regs_pkg::cfg_byte_t reg_datao_o,
	output logic reg_rdvalid_o,
	output cw_io_regs_pkg::hyp_len_t reg_hyplen_o,
	input wire logic trigger_fpa_i,
	input wire logic trigger_nrst_i,
	input wire cw_io_regs_pkg::pin_vec_t trigger_io_i,
	input wire logic trigger_advio_i,
	input wire logic trigger_anapattern_i,
	input wire logic trigger_decodedio_i,
	input wire logic extclk_fpb_i,
	input wire logic extclk_pll_i,
	input wire logic extclk_rearin_i,
	input wire logic clkgen_i,
	input wire logic glitchclk_i,
	output logic trigger_ext_o,
	output logic trigger_o,
	output logic extclk_o,
	output logic fpa_o,
	output logic fpa_oe_o,
	input wire cw_io_regs_pkg::pin_vec_t targetio_i,
	input wire logic uart_tx_i,
	input wire logic usi_out_i,
	output cw_io_regs_pkg::pin_vec_t targetio_o,
	output cw_io_regs_pkg::pin_vec_t targetio_oe_o,
	output logic uart_rx_o,
	output logic usi_in_o,
	output logic targetpower_off_o,
	output logic enable_avrprog_o,
	output logic [1:0] hsglitch_en_o,
	output logic enable_output_nrst_o,
	output logic output_nrst_o,
	output logic enable_output_pdid_o,
	output logic output_pdid_o,
	output logic enable_output_pdic_o,
	output logic output_pdic_o
);

	cw_io_regs_pkg::cfg_byte_t extclk_cfg; // register bank outputs
	cw_io_regs_pkg::cfg_byte_t trigsrc_cfg;
	cw_io_regs_pkg::cfg_byte_t trigmod_cfg;
	cw_io_regs_pkg::io_route_t ioroute_cfg;
	cw_io_regs_pkg::pin_vec_t pins_in; // pads back to the snapshot

	cw_reg_bank cw_reg_bank_i (
		.clk(clk), .reset(reset),
		.reg_address_i(reg_address_i), .reg_bytecnt_i(reg_bytecnt_i),
		.reg_datai_i(reg_datai_i), .reg_write_i(reg_write_i),
		.extclk_cfg_o(extclk_cfg), .trigsrc_cfg_o(trigsrc_cfg),
		.trigmod_cfg_o(trigmod_cfg), .ioroute_cfg_o(ioroute_cfg)
	);

	cw_reg_readback cw_reg_readback_i (
		.clk(clk), .reset(reset),
		.reg_address_i(reg_address_i), .reg_bytecnt_i(reg_bytecnt_i),
		.reg_read_i(reg_read_i), .reg_addrvalid_i(reg_addrvalid_i),
		.reg_hypaddress_i(reg_hypaddress_i),
		.extclk_cfg_i(extclk_cfg), .trigsrc_cfg_i(trigsrc_cfg),
		.trigmod_cfg_i(trigmod_cfg), .ioroute_cfg_i(ioroute_cfg),
		.pins_in_i(pins_in),
		.reg_datao_o(reg_datao_o), .reg_rdvalid_o(reg_rdvalid_o),
		.reg_hyplen_o(reg_hyplen_o)
	);

	cw_trigger_clock_route cw_trigger_clock_route_i (
		.trigsrc_cfg_i(trigsrc_cfg), .trigmod_cfg_i(trigmod_cfg),
		.extclk_cfg_i(extclk_cfg),
		.trigger_fpa_i(trigger_fpa_i), .trigger_nrst_i(trigger_nrst_i),
		.trigger_io_i(trigger_io_i), .trigger_advio_i(trigger_advio_i),
		.trigger_anapattern_i(trigger_anapattern_i),
		.trigger_decodedio_i(trigger_decodedio_i),
		.extclk_fpb_i(extclk_fpb_i), .extclk_pll_i(extclk_pll_i),
		.extclk_rearin_i(extclk_rearin_i), .clkgen_i(clkgen_i),
		.glitchclk_i(glitchclk_i),
		.trigger_ext_o(trigger_ext_o), .trigger_o(trigger_o),
		.extclk_o(extclk_o), .fpa_o(fpa_o), .fpa_oe_o(fpa_oe_o)
	);

	cw_target_io_route cw_target_io_route_i (
		.clk(clk), .reset(reset),
		.ioroute_cfg_i(ioroute_cfg), .targetio_i(targetio_i),
		.uart_tx_i(uart_tx_i), .usi_out_i(usi_out_i),
		.targetio_o(targetio_o), .targetio_oe_o(targetio_oe_o),
		.pins_in_o(pins_in), .uart_rx_o(uart_rx_o), .usi_in_o(usi_in_o),
		.targetpower_off_o(targetpower_off_o), .enable_avrprog_o(enable_avrprog_o),
		.hsglitch_en_o(hsglitch_en_o),
		.enable_output_nrst_o(enable_output_nrst_o), .output_nrst_o(output_nrst_o),
		.enable_output_pdid_o(enable_output_pdid_o), .output_pdid_o(output_pdid_o),
		.enable_output_pdic_o(enable_output_pdic_o), .output_pdic_o(output_pdic_o)
	);

endmodule

`default_nettype wire

// ==== tb_cw_io_regs.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "cw_io_regs_cfg.svh"

module tb_cw_io_regs;

	localparam cw_io_regs_pkg::reg_addr_t addr_extclk = 6'(`CW_EXTCLK_ADDR);
	localparam cw_io_regs_pkg::reg_addr_t addr_trigsrc = 6'(`CW_TRIGSRC_ADDR);
	localparam cw_io_regs_pkg::reg_addr_t addr_trigmod = 6'(`CW_TRIGMOD_ADDR);
	localparam cw_io_regs_pkg::reg_addr_t addr_ioroute = 6'(`CW_IOROUTE_ADDR);
	localparam cw_io_regs_pkg::reg_addr_t addr_ioread = 6'(`CW_IOREAD_ADDR);
	localparam int read_timeout = 6; // cycles to wait for read-valid

	logic clk = 1'b0;
	logic reset;
	cw_io_regs_pkg::reg_addr_t reg_address_i, reg_hypaddress_i;
	cw_io_regs_pkg::byte_cnt_t reg_bytecnt_i;
	cw_io_regs_pkg::cfg_byte_t reg_datai_i, reg_datao_o;
	logic reg_read_i, reg_write_i, reg_addrvalid_i, reg_rdvalid_o;
	cw_io_regs_pkg::hyp_len_t reg_hyplen_o;
	logic trigger_fpa_i, trigger_nrst_i, trigger_advio_i, trigger_anapattern_i;
	logic trigger_decodedio_i;
	cw_io_regs_pkg::pin_vec_t trigger_io_i, targetio_i, targetio_o, targetio_oe_o;
	logic extclk_fpb_i, extclk_pll_i, extclk_rearin_i, clkgen_i, glitchclk_i;
	logic trigger_ext_o, trigger_o, extclk_o, fpa_o, fpa_oe_o;
	logic uart_tx_i, usi_out_i, uart_rx_o, usi_in_o, targetpower_off_o, enable_avrprog_o;
	logic [1:0] hsglitch_en_o;
	logic enable_output_nrst_o, output_nrst_o, enable_output_pdid_o, output_pdid_o;
	logic enable_output_pdic_o, output_pdic_o;

	integer seed = 8;
	int checks = 0;
	int errors = 0;
	int tests = 0;
	int checks_at_start, errors_at_start; // per-test deltas

	cw_io_regs_top cw_io_regs_top_i (.*);

	always #4 clk = ~clk; // 8 ns period

	task automatic check_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		checks++;
		assert (actual === expected) else begin
			$display("[FAIL] %0t %s expected %0h actual %0h", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic start_test();
		checks_at_start = checks;
		errors_at_start = errors;
	endtask

	task automatic finish_test(input string name);
		tests++;
		$display("%s: %0d checks, %0d errors", name, checks - checks_at_start,
			errors - errors_at_start);
	endtask

	task automatic apply_reset();
		@(posedge clk);
		reset <= 1'b1;
		reg_write_i <= 1'b0;
		reg_read_i <= 1'b0;
		reg_addrvalid_i <= 1'b0;
		targetio_i <= '0; // IOREAD snapshot starts at zero
		repeat (2) @(posedge clk);
		reset <= 1'b0;
	endtask

	task automatic write_reg(input cw_io_regs_pkg::reg_addr_t addr, input logic [2:0] idx,
			input cw_io_regs_pkg::cfg_byte_t data);
		@(posedge clk);
		reg_address_i <= addr;
		reg_bytecnt_i <= {13'd0, idx};
		reg_datai_i <= data;
		reg_write_i <= 1'b1;
		@(posedge clk); // write lands here
		reg_write_i <= 1'b0;
	endtask

	// strobe read, then poll read-valid at falling edges
	task automatic read_reg(input cw_io_regs_pkg::reg_addr_t addr, input logic [2:0] idx,
			input logic expect_valid, output cw_io_regs_pkg::cfg_byte_t data);
		int cycles;
		logic seen;
		cycles = 0;
		seen = 1'b0;
		@(posedge clk);
		reg_address_i <= addr;
		reg_bytecnt_i <= {13'd0, idx};
		reg_read_i <= 1'b1;
		reg_addrvalid_i <= 1'b1;
		while (!seen && cycles < read_timeout) begin
			@(posedge clk);
			reg_read_i <= 1'b0; // one-cycle strobe
			cycles++;
			@(negedge clk);
			seen = reg_rdvalid_o;
		end
		data = reg_datao_o;
		if (expect_valid) begin
			if (!seen) begin
				$display("read of address %0d got no read-valid in %0d cycles", addr,
					read_timeout);
				errors++;
			end else begin
				check_value("read latency", 64'(1), 64'(cycles));
			end
		end else begin
			check_value("reg_rdvalid_o", 64'(0), 64'(seen));
			check_value("reg_datao_o", 64'(0), 64'(data));
		end
		@(posedge clk);
		reg_addrvalid_i <= 1'b0;
	endtask

	task automatic verify_bank(input cw_io_regs_pkg::cfg_byte_t ext,
			input cw_io_regs_pkg::cfg_byte_t src, input cw_io_regs_pkg::cfg_byte_t trig_mod,
			input cw_io_regs_pkg::io_route_t route);
		cw_io_regs_pkg::cfg_byte_t data;
		read_reg(addr_extclk, 3'd0, 1'b1, data);
		check_value("reg_datao_o", 64'(ext), 64'(data));
		read_reg(addr_trigsrc, 3'd0, 1'b1, data);
		check_value("reg_datao_o", 64'(src), 64'(data));
		read_reg(addr_trigmod, 3'd0, 1'b1, data);
		check_value("reg_datao_o", 64'(trig_mod), 64'(data));
		for (int b = 0; b < 8; b++) begin
			read_reg(addr_ioroute, 3'(b), 1'b1, data);
			check_value("reg_datao_o", 64'(route[b*8 +: 8]), 64'(data));
		end
	endtask

	task automatic check_hyplen(input cw_io_regs_pkg::reg_addr_t addr, input int len);
		@(posedge clk);
		reg_hypaddress_i <= addr;
		@(negedge clk);
		check_value("reg_hyplen_o", 64'(len), 64'(reg_hyplen_o));
	endtask

	// OR of enabled lines, AND where disabled lines do not count
	function automatic logic combine_trigger(input cw_io_regs_pkg::trig_comb_t mode,
			input logic [5:0] en, input logic [5:0] lines);
		logic any_high;
		logic all_high;
		any_high = 1'b0;
		all_high = 1'b1;
		for (int i = 0; i < 6; i++) begin
			if (en[i] && lines[i]) any_high = 1'b1;
			if (en[i] && !lines[i]) all_high = 1'b0;
		end
		case (mode)
			2'd0: return any_high;
			2'd1: return all_high;
			2'd2: return !all_high;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic select_module(input cw_io_regs_pkg::trig_module_t sel,
			input logic comb, input logic advio, input logic ana, input logic dec);
		case (sel)
			3'd0: return comb;
			3'd1: return advio;
			3'd2: return ana;
			3'd3: return dec;
			default: return 1'b0;
		endcase
	endfunction

	task automatic reset_and_lengths();
		cw_io_regs_pkg::io_route_t route;
		cw_io_regs_pkg::cfg_byte_t data;
		start_test();
		apply_reset();
		route = '0;
		route[0*8 + `CW_PIN_TX] = 1'b1; // pin 1 TX
		route[1*8 + `CW_PIN_RX] = 1'b1; // pin 2 RX
		verify_bank(8'h03, 8'h01, 8'h00, route);
		read_reg(addr_ioread, 3'd0, 1'b1, data);
		check_value("reg_datao_o", 64'(0), 64'(data));
		read_reg(6'd0, 3'd0, 1'b0, data); // unmapped
		check_hyplen(addr_extclk, 1);
		check_hyplen(addr_trigsrc, 1);
		check_hyplen(addr_trigmod, 1);
		check_hyplen(addr_ioroute, 8);
		check_hyplen(addr_ioread, 1);
		check_hyplen(6'd0, 0);
		finish_test("reset and lengths");
	endtask

	task automatic write_readback();
		cw_io_regs_pkg::io_route_t route;
		logic [31:0] rnd;
		cw_io_regs_pkg::cfg_byte_t ext, src, trig_mod;
		start_test();
		apply_reset();
		rnd = $random(seed);
		ext = rnd[7:0];
		src = rnd[15:8];
		trig_mod = rnd[23:16];
		write_reg(addr_extclk, 3'd0, ext);
		write_reg(addr_trigsrc, 3'd0, src);
		write_reg(addr_trigmod, 3'd0, trig_mod);
		for (int b = 0; b < 8; b++) begin
			rnd = $random(seed);
			route[b*8 +: 8] = rnd[7:0];
			write_reg(addr_ioroute, 3'(b), rnd[7:0]);
		end
		verify_bank(ext, src, trig_mod, route);
		rnd = $random(seed);
		write_reg(addr_ioread, 3'd0, rnd[7:0]); // read-only, must be dropped
		verify_bank(ext, src, trig_mod, route);
		finish_test("write and readback");
	endtask

	task automatic trigger_combining();
		logic [31:0] rnd;
		logic [5:0] en;
		logic exp_ext;
		cw_io_regs_pkg::trig_comb_t mode;
		start_test();
		apply_reset();
		for (int m = 0; m < 4; m++) begin
			mode = 2'(m);
			for (int n = 0; n < 6; n++) begin
				rnd = $random(seed);
				en = (n == 0) ? 6'd0 : rnd[5:0]; // first pass all disabled
				write_reg(addr_trigsrc, 3'd0, {mode, en});
				write_reg(addr_trigmod, 3'd0, {5'd0, rnd[10:8]});
				@(posedge clk);
				trigger_fpa_i <= rnd[16];
				trigger_nrst_i <= rnd[17];
				trigger_io_i <= rnd[21:18];
				trigger_advio_i <= rnd[24];
				trigger_anapattern_i <= rnd[25];
				trigger_decodedio_i <= rnd[26];
				@(negedge clk);
				exp_ext = combine_trigger(mode, en, rnd[21:16]);
				check_value("trigger_ext_o", 64'(exp_ext), 64'(trigger_ext_o));
				check_value("trigger_o", 64'(select_module(rnd[10:8], exp_ext, rnd[24],
					rnd[25], rnd[26])), 64'(trigger_o));
			end
		end
		finish_test("trigger combining");
	endtask

	task automatic pin_routing();
		start_test();
		apply_reset(); // pin 1 TX, pin 2 RX
		for (int t = 0; t < 2; t++) begin
			@(posedge clk);
			uart_tx_i <= 1'(t);
			@(negedge clk);
			check_value("targetio_oe_o[0]", 64'(1), 64'(targetio_oe_o[0]));
			check_value("targetio_o[0]", 64'(t), 64'(targetio_o[0]));
		end
		write_reg(addr_ioroute, 3'd2, 8'h20); // pin 3 open-collector TX
		for (int t = 0; t < 2; t++) begin
			@(posedge clk);
			uart_tx_i <= 1'(t);
			@(negedge clk);
			check_value("targetio_oe_o[2]", 64'(1 - t), 64'(targetio_oe_o[2]));
			if (t == 0) check_value("targetio_o[2]", 64'(0), 64'(targetio_o[2]));
		end
		write_reg(addr_ioroute, 3'd3, 8'hc0); // pin 4 GPIO high
		@(negedge clk);
		check_value("targetio_oe_o[3]", 64'(1), 64'(targetio_oe_o[3]));
		check_value("targetio_o[3]", 64'(1), 64'(targetio_o[3]));
		write_reg(addr_ioroute, 3'd3, 8'h80); // pin 4 GPIO low
		@(negedge clk);
		check_value("targetio_o[3]", 64'(0), 64'(targetio_o[3]));
		write_reg(addr_ioroute, 3'd3, 8'h02); // pins 2 and 4 both claim RX
		@(posedge clk);
		targetio_i <= 4'b1000;
		@(negedge clk);
		check_value("uart_rx_o", 64'(0), 64'(uart_rx_o)); // pin 2 wins
		@(posedge clk);
		targetio_i <= 4'b0010;
		@(negedge clk);
		check_value("uart_rx_o", 64'(1), 64'(uart_rx_o));
		write_reg(addr_ioroute, 3'd1, 8'h00); // only pin 4 left
		@(posedge clk);
		targetio_i <= 4'b0111;
		@(negedge clk);
		check_value("uart_rx_o", 64'(0), 64'(uart_rx_o));
		write_reg(addr_ioroute, 3'd2, 8'h28); // pin 3 keeps open-collector TX, adds USI in
		@(posedge clk);
		targetio_i <= 4'b0100;
		@(negedge clk);
		check_value("usi_in_o", 64'(1), 64'(usi_in_o));
		@(posedge clk);
		targetio_i <= 4'b1011;
		@(negedge clk);
		check_value("usi_in_o", 64'(0), 64'(usi_in_o));
		write_reg(addr_ioroute, 3'd5, 8'h02); // power-off, bit 41
		@(posedge clk);
		@(negedge clk);
		check_value("targetio_oe_o", 64'(0), 64'(targetio_oe_o));
		check_value("targetpower_off_o", 64'(1), 64'(targetpower_off_o));
		finish_test("pin routing");
	endtask

	task automatic pin_snapshot();
		logic [31:0] rnd;
		cw_io_regs_pkg::cfg_byte_t data;
		start_test();
		apply_reset();
		for (int n = 0; n < 4; n++) begin
			rnd = $random(seed);
			@(posedge clk);
			targetio_i <= rnd[3:0];
			read_reg(addr_ioread, 3'd0, 1'b1, data); // first edge of the read samples pins
			check_value("reg_datao_o", 64'({4'd0, rnd[3:0]}), 64'(data));
		end
		finish_test("pin snapshot");
	endtask

	task automatic clocks_and_side_outputs();
		logic [31:0] rnd;
		logic exp_fpa, exp_oe;
		start_test();
		apply_reset();
		for (int c = 0; c < 8; c++) begin
			rnd = $random(seed);
			write_reg(addr_extclk, 3'd0, 8'(c));
			@(posedge clk);
			extclk_fpb_i <= rnd[0];
			extclk_pll_i <= rnd[1];
			extclk_rearin_i <= rnd[2];
			@(negedge clk);
			check_value("extclk_o", 64'((c == 1) ? rnd[0] : (c == 2) ? rnd[1] :
				(c == 3) ? rnd[2] : 1'b0), 64'(extclk_o));
		end
		for (int t = 0; t < 2; t++) begin
			for (int a = 0; a < 4; a++) begin
				rnd = $random(seed);
				write_reg(addr_extclk, 3'd0, {3'd0, 2'(a), 3'd0});
				write_reg(addr_trigmod, 3'd0, {4'd0, 1'(t), 3'd1}); // trigger follows advio
				@(posedge clk);
				trigger_advio_i <= rnd[0];
				clkgen_i <= rnd[1];
				glitchclk_i <= rnd[2];
				@(negedge clk);
				exp_oe = (t == 1) || (a != 3);
				exp_fpa = (t == 1 || a == 0) ? rnd[0] : (a == 1) ? rnd[1] : rnd[2];
				check_value("fpa_oe_o", 64'(exp_oe), 64'(fpa_oe_o));
				if (exp_oe) check_value("fpa_o", 64'(exp_fpa), 64'(fpa_o));
			end
		end
		rnd = $random(seed);
		write_reg(addr_ioroute, 3'd4, rnd[7:0]); // glitch byte
		write_reg(addr_ioroute, 3'd5, rnd[15:8] & 8'hfd); // avrprog, power stays on
		write_reg(addr_ioroute, 3'd6, rnd[23:16]); // nrst/PDI pairs
		@(negedge clk);
		check_value("hsglitch_en_o", 64'(rnd[1:0]), 64'(hsglitch_en_o));
		check_value("enable_avrprog_o", 64'(rnd[8]), 64'(enable_avrprog_o));
		check_value("enable_output_nrst_o", 64'(rnd[16]), 64'(enable_output_nrst_o));
		check_value("output_nrst_o", 64'(rnd[17]), 64'(output_nrst_o));
		check_value("enable_output_pdid_o", 64'(rnd[18]), 64'(enable_output_pdid_o));
		check_value("output_pdid_o", 64'(rnd[19]), 64'(output_pdid_o));
		check_value("enable_output_pdic_o", 64'(rnd[20]), 64'(enable_output_pdic_o));
		check_value("output_pdic_o", 64'(rnd[21]), 64'(output_pdic_o));
		finish_test("clocks and side outputs");
	endtask

	initial begin
		reset <= 1'b1;
		reg_address_i <= '0;
		reg_bytecnt_i <= '0;
		reg_datai_i <= '0;
		reg_read_i <= 1'b0;
		reg_write_i <= 1'b0;
		reg_addrvalid_i <= 1'b0;
		reg_hypaddress_i <= '0;
		trigger_fpa_i <= 1'b0;
		trigger_nrst_i <= 1'b0;
		trigger_io_i <= '0;
		trigger_advio_i <= 1'b0;
		trigger_anapattern_i <= 1'b0;
		trigger_decodedio_i <= 1'b0;
		extclk_fpb_i <= 1'b0;
		extclk_pll_i <= 1'b0;
		extclk_rearin_i <= 1'b0;
		clkgen_i <= 1'b0;
		glitchclk_i <= 1'b0;
		targetio_i <= '0;
		uart_tx_i <= 1'b1; // uart idles high
		usi_out_i <= 1'b0;
		reset_and_lengths();
		write_readback();
		trigger_combining();
		pin_routing();
		pin_snapshot();
		clocks_and_side_outputs();
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== cw_io_regs.f ====
+incdir+.
cw_io_regs_pkg.sv
cw_reg_bank.sv
cw_reg_readback.sv
cw_trigger_clock_route.sv
cw_target_io_route.sv
cw_io_regs_top.sv
tb_cw_io_regs.sv

// ==== Makefile ====
SRCS := $(filter-out +incdir+%,$(shell cat cw_io_regs.f)) cw_io_regs_cfg.svh

.PHONY: run clean

run: obj_dir/Vtb_cw_io_regs
	obj_dir/Vtb_cw_io_regs | tee sim.log
	grep -q "Testbench passed" sim.log

obj_dir/Vtb_cw_io_regs: cw_io_regs.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_cw_io_regs -f cw_io_regs.f

clean:
	rm -rf obj_dir sim.log
